// File: src/l2_cfg_pkg.sv
// l2 cache geometry
// default sizes for the four-way cache and its eviction buffer
package l2_cfg_pkg;

    // word address and data widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // two index bits, four sets
    localparam int SET_W = 2;

    // eviction write buffer entries
    localparam int EWB_DEPTH = 4;

    // fixed by the 3-bit pseudo-LRU tree
    localparam int NUM_WAYS = 4;

endpackage : l2_cfg_pkg

// File: src/l2_types_pkg.sv
// l2 cache types
// way index, pseudo-LRU tree bits and controller states
package l2_types_pkg;

    // one of four ways
    typedef logic [1:0] way_t;

    // tree pseudo-LRU bits for one set
    // bit 2 half used last, 1 for upper half
    // bit 1 way 1 used last within ways 0/1
    // bit 0 way 3 used last within ways 2/3
    typedef logic [2:0] plru_t;

    // request state machine
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_evict,
        st_refill
    } l2_state_t;

endpackage : l2_types_pkg

// File: src/ewb_if.sv
// eviction write buffer interface
// controller pushes and looks up, buffer answers, memory port drains
`timescale 1ns/10ps

interface ewb_if
    import l2_cfg_pkg::*;
#(
    parameter int ADDR_W = l2_cfg_pkg::ADDR_W,
    parameter int DATA_W = l2_cfg_pkg::DATA_W
);

    // dirty victim in
    logic              push;
    logic [ADDR_W-1:0] push_addr;
    logic [DATA_W-1:0] push_data;

    // address match and in-place write
    logic [ADDR_W-1:0] lookup_addr;
    logic              update;
    logic [DATA_W-1:0] update_data;
    logic              match;
    logic [DATA_W-1:0] match_data;

    // buffer status and head entry
    logic              full;
    logic              empty;
    logic [ADDR_W-1:0] head_addr;
    logic [DATA_W-1:0] head_data;
    logic              pop;

    modport ctrl (
        output push, push_addr, push_data, lookup_addr, update, update_data,
        input  full, match, match_data
    );

    modport buffer (
        input  push, push_addr, push_data, lookup_addr, update, update_data, pop,
        output full, match, match_data, empty, head_addr, head_data
    );

    modport drain (
        output pop,
        input  empty, head_addr, head_data
    );

endinterface : ewb_if

// File: src/l2_way_arrays.sv
// l2 way arrays
// tag, valid, dirty, data and pseudo-LRU storage for four ways,
// combinational hit detect and victim choice
`timescale 1ns/10ps

module l2_way_arrays
    import l2_cfg_pkg::*;
    import l2_types_pkg::*;
#(
    parameter int ADDR_W = l2_cfg_pkg::ADDR_W,
    parameter int DATA_W = l2_cfg_pkg::DATA_W,
    parameter int SET_W  = l2_cfg_pkg::SET_W
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] address,
    input  logic [DATA_W-1:0] wdata,
    input  logic [DATA_W-1:0] fill_data,
    input  logic              touch,
    input  logic              write_hit,
    input  logic              fill,
    input  logic              evict,
    output logic              hit,
    output logic [DATA_W-1:0] rdata,
    output logic              victim_dirty,
    output logic [ADDR_W-1:0] victim_addr,
    output logic [DATA_W-1:0] victim_data
);

    localparam int SETS  = 1 << SET_W;
    localparam int TAG_W = ADDR_W - SET_W;

    logic [TAG_W-1:0]    tag_q   [SETS][NUM_WAYS];
    logic [DATA_W-1:0]   data_q  [SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q [SETS];
    logic [NUM_WAYS-1:0] dirty_q [SETS];
    plru_t               plru_q  [SETS];

    logic [SET_W-1:0] set_idx;
    logic [TAG_W-1:0] addr_tag;
    way_t             hit_way;
    way_t             victim;
    plru_t            lru;
    plru_t            lru_next;

    assign set_idx  = address[SET_W-1:0];
    assign addr_tag = address[ADDR_W-1:SET_W];
    assign lru      = plru_q[set_idx];

    // tag compare over all ways
    always_comb
    begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (valid_q[set_idx][w] && tag_q[set_idx][w] == addr_tag)
            begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // lowest invalid way first, otherwise walk the tree away from recent use
    always_comb
    begin
        if (!(&valid_q[set_idx]))
        begin
            victim = '0;
            for (int w = NUM_WAYS - 1; w >= 0; w--)
            begin
                if (!valid_q[set_idx][w])
                    victim = way_t'(w);
            end
        end
        else if (!lru[2])
            victim = lru[0] ? way_t'(2) : way_t'(3);
        else
            victim = lru[1] ? way_t'(0) : way_t'(1);
    end

    // point the tree at the hit way
    always_comb
    begin
        case (hit_way)
            2'd0:    lru_next = {1'b0, 1'b0, lru[0]};
            2'd1:    lru_next = {1'b0, 1'b1, lru[0]};
            2'd2:    lru_next = {1'b1, lru[1], 1'b0};
            default: lru_next = {1'b1, lru[1], 1'b1};
        endcase
    end

    assign rdata        = data_q[set_idx][hit_way];
    assign victim_dirty = valid_q[set_idx][victim] & dirty_q[set_idx][victim];
    assign victim_addr  = {tag_q[set_idx][victim], set_idx};
    assign victim_data  = data_q[set_idx][victim];

    // valid and LRU state
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                valid_q[s] <= '0;
                plru_q[s]  <= '0;
            end
        end
        else
        begin
            if (touch)
                plru_q[set_idx] <= lru_next;
            // refill slot is the way invalidated by evict
            if (fill)
                valid_q[set_idx][victim] <= 1'b1;
            else if (evict)
                valid_q[set_idx][victim] <= 1'b0;
        end
    end

    // tags, data and dirty bits
    always_ff @(posedge clk)
    begin
        if (write_hit)
        begin
            data_q[set_idx][hit_way]  <= wdata;
            dirty_q[set_idx][hit_way] <= 1'b1;
        end
        if (fill)
        begin
            tag_q[set_idx][victim]   <= addr_tag;
            data_q[set_idx][victim]  <= fill_data;
            dirty_q[set_idx][victim] <= 1'b0;
        end
    end

endmodule : l2_way_arrays

// File: src/l2_cache_control.sv
// l2 cache controller
// request FSM: lookup, dirty victim eviction into the buffer, refill
`timescale 1ns/10ps

module l2_cache_control
    import l2_cfg_pkg::*;
    import l2_types_pkg::*;
#(
    parameter int ADDR_W = l2_cfg_pkg::ADDR_W,
    parameter int DATA_W = l2_cfg_pkg::DATA_W
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_read,
    input  logic              mem_write,
    input  logic [ADDR_W-1:0] mem_address,
    input  logic [DATA_W-1:0] mem_wdata,
    input  logic              hit,
    input  logic              victim_dirty,
    input  logic [ADDR_W-1:0] victim_addr,
    input  logic [DATA_W-1:0] victim_data,
    input  logic              fill_done,
    output logic              mem_resp,
    output logic              use_ewb_data,
    output logic              touch,
    output logic              write_hit,
    output logic              fill,
    output logic              evict,
    output logic              fill_req,
    output logic [ADDR_W-1:0] fill_addr,
    ewb_if.ctrl               ewb
);

    l2_state_t state;
    l2_state_t state_next;

    logic req;
    assign req = mem_read | mem_write;

    // payload paths straight from the request and the victim
    assign ewb.lookup_addr = mem_address;
    assign ewb.update_data = mem_wdata;
    assign ewb.push_addr   = victim_addr;
    assign ewb.push_data   = victim_data;
    assign fill_addr       = mem_address;

    // refill request held for the whole state
    assign fill_req = (state == st_refill);

    always_comb
    begin
        state_next   = state;
        mem_resp     = 1'b0;
        use_ewb_data = 1'b0;
        touch        = 1'b0;
        write_hit    = 1'b0;
        fill         = 1'b0;
        evict        = 1'b0;
        ewb.push     = 1'b0;
        ewb.update   = 1'b0;

        case (state)
            st_idle:
            begin
                if (req)
                    state_next = st_lookup;
            end

            st_lookup:
            begin
                if (hit)
                begin
                    mem_resp   = 1'b1;
                    touch      = 1'b1;
                    write_hit  = mem_write;
                    state_next = st_idle;
                end
                else if (ewb.match)
                begin
                    // line sits in the buffer, serve it there
                    mem_resp     = 1'b1;
                    use_ewb_data = 1'b1;
                    ewb.update   = mem_write;
                    state_next   = st_idle;
                end
                else if (victim_dirty)
                    state_next = st_evict;
                else
                    state_next = st_refill;
            end

            st_evict:
            begin
                // hold here until the buffer has room
                if (!ewb.full)
                begin
                    ewb.push   = 1'b1;
                    evict      = 1'b1;
                    state_next = st_refill;
                end
            end

            st_refill:
            begin
                if (fill_done)
                begin
                    fill       = 1'b1;
                    state_next = st_lookup;
                end
            end

            default:
                state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= st_idle;
        else
            state <= state_next;
    end

endmodule : l2_cache_control

// File: src/evict_write_buffer.sv
// eviction write buffer
// circular FIFO of dirty victims, searchable by address,
// with in-place write of a matching entry
`timescale 1ns/10ps

module evict_write_buffer
    import l2_cfg_pkg::*;
#(
    parameter int ADDR_W    = l2_cfg_pkg::ADDR_W,
    parameter int DATA_W    = l2_cfg_pkg::DATA_W,
    parameter int EWB_DEPTH = l2_cfg_pkg::EWB_DEPTH
)
(
    input  logic clk,
    input  logic rst,
    ewb_if.buffer ewb
);

    // depth is a power of two, pointers wrap on their own
    localparam int PTR_W = $clog2(EWB_DEPTH);
    localparam int CNT_W = $clog2(EWB_DEPTH + 1);

    logic [ADDR_W-1:0] addr_q [EWB_DEPTH];
    logic [DATA_W-1:0] data_q [EWB_DEPTH];
    logic [PTR_W-1:0]  head;
    logic [PTR_W-1:0]  tail;
    logic [CNT_W-1:0]  count;
    logic [EWB_DEPTH-1:0] hit_vec;

    logic do_pop;
    assign do_pop = ewb.pop & ~ewb.empty;

    assign ewb.full      = (count == CNT_W'(EWB_DEPTH));
    assign ewb.empty     = (count == '0);
    assign ewb.head_addr = addr_q[head];
    assign ewb.head_data = data_q[head];

    // live entries matching the lookup address
    // head leaving this cycle is skipped so an update is not lost
    always_comb
    begin
        logic [PTR_W-1:0] off;
        hit_vec        = '0;
        ewb.match_data = data_q[0];
        for (int i = 0; i < EWB_DEPTH; i++)
        begin
            off = PTR_W'(i) - head;
            if (CNT_W'(off) < count && addr_q[i] == ewb.lookup_addr
                && !(do_pop && PTR_W'(i) == head))
            begin
                hit_vec[i]     = 1'b1;
                ewb.match_data = data_q[i];
            end
        end
    end

    assign ewb.match = |hit_vec;

    // pointers and fill level
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end
        else
        begin
            if (ewb.push)
                tail <= tail + 1'b1;
            if (do_pop)
                head <= head + 1'b1;
            if (ewb.push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !ewb.push)
                count <= count - 1'b1;
        end
    end

    // entry storage
    always_ff @(posedge clk)
    begin
        if (ewb.push)
        begin
            addr_q[tail] <= ewb.push_addr;
            data_q[tail] <= ewb.push_data;
        end
        for (int i = 0; i < EWB_DEPTH; i++)
        begin
            if (ewb.update && hit_vec[i])
                data_q[i] <= ewb.update_data;
        end
    end

endmodule : evict_write_buffer

// File: src/pmem_port.sv
// physical memory port
// arbitrates refills and eviction buffer drains on one memory port,
// request held until pmem_resp
`timescale 1ns/10ps

module pmem_port
    import l2_cfg_pkg::*;
#(
    parameter int ADDR_W = l2_cfg_pkg::ADDR_W,
    parameter int DATA_W = l2_cfg_pkg::DATA_W
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              fill_req,
    input  logic [ADDR_W-1:0] fill_addr,
    input  logic [DATA_W-1:0] pmem_rdata,
    input  logic              pmem_resp,
    output logic              fill_done,
    output logic [DATA_W-1:0] fill_data,
    output logic              pmem_read,
    output logic              pmem_write,
    output logic [ADDR_W-1:0] pmem_address,
    output logic [DATA_W-1:0] pmem_wdata,
    ewb_if.drain              ewb
);

    typedef enum logic [1:0] {
        pm_idle,
        pm_fill,
        pm_drain
    } pm_state_t;

    pm_state_t state;

    assign pmem_read    = (state == pm_fill);
    assign pmem_write   = (state == pm_drain);
    assign pmem_address = (state == pm_drain) ? ewb.head_addr : fill_addr;
    // head data stays valid until the pop in the pmem_resp cycle
    assign pmem_wdata   = ewb.head_data;

    assign fill_done = pmem_read & pmem_resp;
    assign fill_data = pmem_rdata;
    assign ewb.pop   = pmem_write & pmem_resp;

    // refill wins when idle, a started drain always runs to its end
    always_ff @(posedge clk)
    begin
        if (rst)
            state <= pm_idle;
        else
        begin
            case (state)
                pm_idle:
                begin
                    if (fill_req)
                        state <= pm_fill;
                    else if (!ewb.empty)
                        state <= pm_drain;
                end
                pm_fill, pm_drain:
                begin
                    if (pmem_resp)
                        state <= pm_idle;
                end
                default:
                    state <= pm_idle;
            endcase
        end
    end

endmodule : pmem_port

// File: src/l2_cache_top.sv
// l2 cache top level
// four-way set-associative cache with eviction write buffer
// between a CPU request port and a physical memory port
`timescale 1ns/10ps

module l2_cache_top
    import l2_cfg_pkg::*;
#(
    parameter int ADDR_W    = l2_cfg_pkg::ADDR_W,
    parameter int DATA_W    = l2_cfg_pkg::DATA_W,
    parameter int SET_W     = l2_cfg_pkg::SET_W,
    parameter int EWB_DEPTH = l2_cfg_pkg::EWB_DEPTH
)
(
    input  logic              clk,
    input  logic              rst,
    // CPU side
    input  logic              mem_read,
    input  logic              mem_write,
    input  logic [ADDR_W-1:0] mem_address,
    input  logic [DATA_W-1:0] mem_wdata,
    output logic [DATA_W-1:0] mem_rdata,
    output logic              mem_resp,
    // memory side
    output logic              pmem_read,
    output logic              pmem_write,
    output logic [ADDR_W-1:0] pmem_address,
    output logic [DATA_W-1:0] pmem_wdata,
    input  logic [DATA_W-1:0] pmem_rdata,
    input  logic              pmem_resp
);

    logic              hit;
    logic              victim_dirty;
    logic [ADDR_W-1:0] victim_addr;
    logic [DATA_W-1:0] victim_data;
    logic [DATA_W-1:0] cache_rdata;
    logic              touch;
    logic              write_hit;
    logic              fill;
    logic              evict;
    logic              use_ewb_data;
    logic              fill_req;
    logic [ADDR_W-1:0] fill_addr;
    logic              fill_done;
    logic [DATA_W-1:0] fill_data;

    ewb_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) ewb ();

    // buffered line wins only when the arrays missed
    assign mem_rdata = use_ewb_data ? ewb.match_data : cache_rdata;

    l2_way_arrays #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .SET_W(SET_W)) u_arrays (
        .clk          (clk),
        .rst          (rst),
        .address      (mem_address),
        .wdata        (mem_wdata),
        .fill_data    (fill_data),
        .touch        (touch),
        .write_hit    (write_hit),
        .fill         (fill),
        .evict        (evict),
        .hit          (hit),
        .rdata        (cache_rdata),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_data  (victim_data)
    );

    l2_cache_control #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_control (
        .clk          (clk),
        .rst          (rst),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_data  (victim_data),
        .fill_done    (fill_done),
        .mem_resp     (mem_resp),
        .use_ewb_data (use_ewb_data),
        .touch        (touch),
        .write_hit    (write_hit),
        .fill         (fill),
        .evict        (evict),
        .fill_req     (fill_req),
        .fill_addr    (fill_addr),
        .ewb          (ewb.ctrl)
    );

    evict_write_buffer #(
        .ADDR_W    (ADDR_W),
        .DATA_W    (DATA_W),
        .EWB_DEPTH (EWB_DEPTH)
    ) u_ewb (
        .clk (clk),
        .rst (rst),
        .ewb (ewb.buffer)
    );

    pmem_port #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_pmem (
        .clk          (clk),
        .rst          (rst),
        .fill_req     (fill_req),
        .fill_addr    (fill_addr),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp),
        .fill_done    (fill_done),
        .fill_data    (fill_data),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .ewb          (ewb.drain)
    );

endmodule : l2_cache_top

// File: verif/clk_gen.sv
// testbench clock and reset source
// free-running clock, synchronous reset held for a few cycles
`timescale 1ns/10ps

module clk_gen
#(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
)
(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a rising edge like any other input
    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule : clk_gen

// File: verif/tb_l2_cache.sv
// l2 cache testbench
// trace-driven requests, memory model with random latency,
// drain address checks and a final readback against a reference image
`timescale 1ns/10ps

module tb_l2_cache
    import l2_cfg_pkg::*;
();

    localparam string TRACE_FILE = "verif/l2_trace.txt";

    logic              clk;
    logic              rst;
    logic              mem_read;
    logic              mem_write;
    logic [ADDR_W-1:0] mem_address;
    logic [DATA_W-1:0] mem_wdata;
    logic [DATA_W-1:0] mem_rdata;
    logic              mem_resp;
    logic              pmem_read;
    logic              pmem_write;
    logic [ADDR_W-1:0] pmem_address;
    logic [DATA_W-1:0] pmem_wdata;
    logic [DATA_W-1:0] pmem_rdata = '0;
    logic              pmem_resp  = 1'b0;

    // trace contents
    byte               op_q   [$];
    logic [ADDR_W-1:0] addr_q [$];
    logic [DATA_W-1:0] data_q [$];

    // backing memory, expected image, observed drain writes
    logic [DATA_W-1:0] mem_model [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0] ref_mem   [logic [ADDR_W-1:0]];
    logic [ADDR_W-1:0] drain_q   [$];

    int errors = 0;
    int checks = 0;
    bit trace_loaded = 1'b0;

    // memory model request as seen mid-cycle
    logic              req_rd = 1'b0;
    logic              req_wr = 1'b0;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    int                lat = 0;

    clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(4)) u_clk (
        .clk (clk),
        .rst (rst)
    );

    l2_cache_top #(
        .ADDR_W    (ADDR_W),
        .DATA_W    (DATA_W),
        .SET_W     (SET_W),
        .EWB_DEPTH (EWB_DEPTH)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    // untouched word: a5a5 over the address
    function automatic logic [DATA_W-1:0] initial_word(input logic [ADDR_W-1:0] a);
        return {16'ha5a5, a};
    endfunction

    function automatic logic [DATA_W-1:0] model_word(input logic [ADDR_W-1:0] a);
        if (mem_model.exists(a))
            return mem_model[a];
        return initial_word(a);
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAILED %s at %0t: expected %h, got %h", name, $time, expected, actual);
        end
    endtask

    // sample the port mid-cycle, count drain writes on their response
    always @(negedge clk)
    begin
        req_rd    = pmem_read;
        req_wr    = pmem_write;
        req_addr  = pmem_address;
        req_wdata = pmem_wdata;
        if (pmem_write === 1'b1 && pmem_resp)
            drain_q.push_back(pmem_address);
    end

    // answer after 1 to 4 cycles, resp for one cycle
    // write data taken as it stands in the resp cycle
    always @(posedge clk)
    begin
        if (rst)
        begin
            pmem_resp <= 1'b0;
            lat       <= 0;
        end
        else if (pmem_resp)
        begin
            pmem_resp <= 1'b0;
            if (req_wr === 1'b1)
                mem_model[req_addr] = req_wdata;
        end
        else if (req_rd === 1'b1 || req_wr === 1'b1)
        begin
            if (lat == 0)
                lat <= $urandom_range(4, 1);
            else if (lat == 1)
            begin
                lat       <= 0;
                pmem_resp <= 1'b1;
                if (req_wr !== 1'b1)
                    pmem_rdata <= model_word(req_addr);
            end
            else
                lat <= lat - 1;
        end
    end

    task automatic load_trace();
        int                fd;
        int                n;
        string             line;
        byte               op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0)
        begin
            $display("could not open the trace file %s", TRACE_FILE);
            errors++;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            // skip comments and blank lines
            if (line.len() > 0 && line.getc(0) != "#")
            begin
                n = $sscanf(line, "%c %h %h", op, addr, data);
                if (n == 3)
                begin
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    data_q.push_back(data);
                end
            end
        end
        $fclose(fd);
    endtask

    // one CPU request, held until mem_resp
    task automatic run_request(input bit is_write, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata,
                               output logic [DATA_W-1:0] rdata,
                               output int cycles, output bit saw_pwrite);
        cycles     = 0;
        saw_pwrite = 1'b0;
        @(posedge clk);
        mem_read    <= !is_write;
        mem_write   <= is_write;
        mem_address <= addr;
        mem_wdata   <= wdata;
        do
        begin
            @(negedge clk);
            cycles++;
            if (pmem_write)
                saw_pwrite = 1'b1;
        end while (!mem_resp);
        rdata = mem_rdata;
        @(posedge clk);
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
    endtask

    // a hit answers in the lookup cycle with no writeback
    task automatic check_hit(input int cycles, input bit saw_pwrite);
        check_value("mem_resp latency", 2, cycles);
        check_value("pmem_write", 0, saw_pwrite);
    endtask

    task automatic check_drain(input logic [ADDR_W-1:0] expected);
        while (drain_q.size() == 0)
            @(posedge clk);
        check_value("pmem_address", DATA_W'(expected), DATA_W'(drain_q.pop_front()));
    endtask

    task automatic run_op(input int i);
        logic [DATA_W-1:0] rdata;
        int                cycles;
        bit                saw_pwrite;
        case (op_q[i])
            "R", "r":
            begin
                if (!ref_mem.exists(addr_q[i]))
                    ref_mem[addr_q[i]] = initial_word(addr_q[i]);
                run_request(1'b0, addr_q[i], '0, rdata, cycles, saw_pwrite);
                check_value($sformatf("mem_rdata @%h", addr_q[i]), data_q[i], rdata);
                if (op_q[i] == "r")
                    check_hit(cycles, saw_pwrite);
            end
            "W", "w":
            begin
                ref_mem[addr_q[i]] = data_q[i];
                run_request(1'b1, addr_q[i], data_q[i], rdata, cycles, saw_pwrite);
                if (op_q[i] == "w")
                    check_hit(cycles, saw_pwrite);
            end
            "V":
                check_drain(addr_q[i]);
            "M":
                check_value($sformatf("memory word @%h", addr_q[i]), data_q[i],
                            model_word(addr_q[i]));
            "I":
                repeat (int'(data_q[i])) @(posedge clk);
            default:
            begin
                errors++;
                $display("trace line %0d holds an unknown operation", i);
            end
        endcase
    endtask

    // every address the trace used, read back through the cache
    task automatic check_readback();
        logic [DATA_W-1:0] rdata;
        int                cycles;
        bit                saw_pwrite;
        foreach (ref_mem[a])
        begin
            run_request(1'b0, a, '0, rdata, cycles, saw_pwrite);
            check_value($sformatf("readback mem_rdata @%h", a), ref_mem[a], rdata);
        end
    endtask

    initial
    begin
        void'($urandom(32'hb2ce_2329));
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;
        load_trace();
        trace_loaded = 1'b1;
        wait (rst === 1'b0);
        for (int i = 0; i < op_q.size(); i++)
            run_op(i);
        // let the buffer drain before the final pass
        repeat (64) @(posedge clk);
        check_readback();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // 200 cycles per trace line
    initial
    begin
        wait (trace_loaded);
        repeat ((op_q.size() + 1) * 200) @(posedge clk);
        $display("timeout: the trace did not finish in %0d cycles", (op_q.size() + 1) * 200);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule : tb_l2_cache

// File: flist.f
src/l2_cfg_pkg.sv
src/l2_types_pkg.sv
src/ewb_if.sv
src/l2_way_arrays.sv
src/l2_cache_control.sv
src/evict_write_buffer.sv
src/pmem_port.sv
src/l2_cache_top.sv
verif/clk_gen.sv
verif/tb_l2_cache.sv

// File: run.sh
#!/bin/sh
# build and run the l2 cache testbench with Verilator, fail on the fail message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_l2_cache \
    -o sim_l2 > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_l2 > sim.log 2>&1
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0

// File: verif/l2_trace.txt
# op addr data: R read expecting data, W write data, lower case r/w must hit
# V addr next drain write address, M addr data memory word, I data idle cycles
R 0100 a5a50100
R 0203 a5a50203
w 0100 11112222
r 0100 11112222
w 0203 33334444
r 0203 33334444
W 0001 aaaa0001
W 0005 aaaa0005
W 0009 aaaa0009
W 000d aaaa000d
R 0005 aaaa0005
R 0011 a5a50011
V 0009 00000000
R 0001 aaaa0001
R 0015 a5a50015
V 000d 00000000
R 0019 a5a50019
V 0005 00000000
I 0000 00000020
M 0009 aaaa0009
M 000d aaaa000d
M 0005 aaaa0005
W 0002 bbbb0002
W 0006 bbbb0006
W 000a bbbb000a
W 000e bbbb000e
R 0012 a5a50012
R 0002 bbbb0002
W 0002 cccc0002
R 0002 cccc0002
R 0016 a5a50016
R 001a a5a5001a
R 001e a5a5001e
R 0022 a5a50022
I 0000 00000040
M 0002 cccc0002
M 0006 bbbb0006
